// File: include/cache_defines.svh
// Cache geometry macros: address and word widths, line size, sets, ways and derived widths.
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Byte address width of the host port.
`define CACHE_ADDR_W 16
`define CACHE_WORD_W 32

// Words per line, sets and ways.
`define CACHE_LINE_WORDS 8
`define CACHE_SETS 8
`define CACHE_WAYS 2

// Derived field widths.
`define CACHE_OFS_W $clog2(`CACHE_LINE_WORDS)
`define CACHE_SET_W $clog2(`CACHE_SETS)
`define CACHE_WAY_W $clog2(`CACHE_WAYS)
`define CACHE_TAG_W (`CACHE_ADDR_W - 2 - `CACHE_OFS_W - `CACHE_SET_W)

`endif

// File: src/cache_geom_pkg.sv
// Cache geometry types: way, set, offset, tag, tag entry, tag set, data row, data address.
`include "cache_defines.svh"

package cache_geom_pkg;

    typedef logic [`CACHE_WAY_W-1:0] way_t;
    typedef logic [`CACHE_SET_W-1:0] set_idx_t;
    typedef logic [`CACHE_OFS_W-1:0] line_ofs_t;
    typedef logic [`CACHE_TAG_W-1:0] tag_t;

    // One way of a set.
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // Tag RAM word, all ways plus the round-robin victim pointer.
    typedef struct packed {
        way_t next;
        tag_entry_t [`CACHE_WAYS-1:0] ways;
    } tag_set_t;

    // Data RAM word, one word per way.
    typedef logic [`CACHE_WAYS-1:0][`CACHE_WORD_W-1:0] data_row_t;

    typedef struct packed {
        set_idx_t set;
        line_ofs_t ofs;
    } data_addr_t;

endpackage

// File: src/mem_bus_pkg.sv
// Memory bus types: data word, byte strobe and word address.
`include "cache_defines.svh"

package mem_bus_pkg;

    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef logic [`CACHE_WORD_W/8-1:0] strobe_t;
    typedef logic [`CACHE_ADDR_W-3:0] word_addr_t;

endpackage

// File: src/mem_port_if.sv
// Word memory port interface between the cache controller and the line sequencer.
`timescale 1ns/1ps

interface mem_port_if;

    logic re;
    mem_bus_pkg::strobe_t we;
    mem_bus_pkg::word_addr_t addr;
    mem_bus_pkg::word_t wdata;
    mem_bus_pkg::word_t rdata;
    logic ready;

    // Requester side.
    modport ctrl (output re, we, addr, wdata, input rdata, ready);

    // Sequencer side.
    modport seq (input re, we, addr, wdata, output rdata, ready);

endinterface

// File: src/sdp_ram.sv
// Simple dual-port synchronous RAM with per-lane write mask and a generic payload type.
`timescale 1ns/1ps

module sdp_ram #(
    parameter type payload_t = logic [31:0],
    parameter int DEPTH = 16,
    parameter int LANES = 1,
    localparam int AW = $clog2(DEPTH),
    localparam int LANE_W = $bits(payload_t) / LANES
) (
    input  logic clk,
    input  logic we,
    input  logic [LANES-1:0] wmask,
    input  logic [AW-1:0] waddr,
    input  payload_t wdata,
    input  logic [AW-1:0] raddr,
    output payload_t rdata
);

    logic [LANES-1:0][LANE_W-1:0] mem [DEPTH];
    logic [LANES-1:0][LANE_W-1:0] wlanes;

    assign wlanes = wdata;

    // Read returns the old word on a same-address write.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < LANES; i++) begin
                if (wmask[i]) begin
                    mem[waddr][i] <= wlanes[i];
                end
            end
        end
        rdata <= mem[raddr];
    end

endmodule

// File: src/tag_lookup.sv
// Tag compare, hit-way encoding, victim status and tag set update.
`timescale 1ns/1ps
`include "cache_defines.svh"

module tag_lookup (
    input  cache_geom_pkg::tag_set_t tags,
    input  cache_geom_pkg::tag_t req_tag,
    input  cache_geom_pkg::way_t upd_way,
    input  cache_geom_pkg::tag_entry_t upd_entry,
    input  logic advance,
    output logic hit,
    output cache_geom_pkg::way_t hit_way,
    output logic victim_dirty,
    output cache_geom_pkg::tag_t victim_tag,
    output cache_geom_pkg::tag_set_t new_set
);

    logic [`CACHE_WAYS-1:0] match;
    cache_geom_pkg::tag_entry_t victim;

    // Only valid ways can match.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            match[w] = tags.ways[w].valid && (tags.ways[w].tag == req_tag);
            if (match[w]) begin
                hit_way = cache_geom_pkg::way_t'(w);
            end
        end
    end

    assign hit = |match;

    // Victim is whatever way the round-robin pointer names.
    assign victim = tags.ways[tags.next];
    assign victim_dirty = victim.valid && victim.dirty;
    assign victim_tag = victim.tag;

    always_comb begin
        new_set = tags;
        new_set.ways[upd_way] = upd_entry;
        // Allocation moves the pointer on.
        if (advance) begin
            if (tags.next == `CACHE_WAYS - 1) begin
                new_set.next = '0;
            end else begin
                new_set.next = cache_geom_pkg::way_t'(tags.next + 1'b1);
            end
        end
    end

endmodule

// File: src/line_transfer.sv
// Line sequencer: dirty victim write-back followed by line fill on the external port.
`timescale 1ns/1ps
`include "cache_defines.svh"

module line_transfer (
    input  logic clk,
    input  logic rst_n,
    mem_port_if.seq cmd,
    output cache_geom_pkg::data_addr_t rd_addr,
    input  mem_bus_pkg::word_t victim_data,
    output logic fill_we,
    output cache_geom_pkg::line_ofs_t fill_ofs,
    output logic ext_re,
    output mem_bus_pkg::strobe_t ext_we,
    output mem_bus_pkg::word_addr_t ext_addr,
    output mem_bus_pkg::word_t ext_wdata,
    input  mem_bus_pkg::word_t ext_rdata,
    input  logic ext_ready
);

    localparam int LINE_W = `CACHE_ADDR_W - 2 - `CACHE_OFS_W;

    typedef enum logic [2:0] {
        LT_IDLE,
        LT_WB_LOAD,
        LT_WB,
        LT_FILL,
        LT_DONE
    } lt_state_t;

    lt_state_t state;
    cache_geom_pkg::line_ofs_t cnt;
    logic [LINE_W-1:0] fill_line;
    logic [LINE_W-1:0] wb_line;
    logic beat;
    logic last;

    // A beat is any cycle where a request meets ready.
    assign beat = (ext_re || |ext_we) && ext_ready;
    assign last = cnt == `CACHE_LINE_WORDS - 1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LT_IDLE;
            cnt <= '0;
        end else begin
            case (state)
                LT_IDLE: begin
                    cnt <= '0;
                    if (|cmd.we) begin
                        state <= LT_WB_LOAD;
                    end else if (cmd.re) begin
                        state <= LT_FILL;
                    end
                end
                // One cycle to get the first victim word out of the RAM.
                LT_WB_LOAD: state <= LT_WB;
                LT_WB, LT_FILL: begin
                    if (beat) begin
                        cnt <= last ? '0 : cnt + 1'b1;
                        if (last) begin
                            state <= (state == LT_WB) ? LT_FILL : LT_DONE;
                        end
                    end
                end
                default: state <= LT_IDLE;
            endcase
        end
    end

    // Line addresses are taken with the start command.
    always_ff @(posedge clk) begin
        if (state == LT_IDLE && (cmd.re || |cmd.we)) begin
            fill_line <= cmd.addr[`CACHE_ADDR_W-3:`CACHE_OFS_W];
            wb_line <= cmd.wdata[`CACHE_ADDR_W-3:`CACHE_OFS_W];
        end
    end

    assign ext_re = state == LT_FILL;
    assign ext_we = (state == LT_WB) ? '1 : '0;
    assign ext_addr = {(state == LT_WB) ? wb_line : fill_line, cnt};
    assign ext_wdata = victim_data;

    // Read one word ahead once the current word is accepted, else hold.
    assign rd_addr = {fill_line[`CACHE_SET_W-1:0], (state == LT_WB && beat) ? cnt + 1'b1 : cnt};

    assign fill_we = state == LT_FILL && beat;
    assign fill_ofs = cnt;

    assign cmd.rdata = ext_rdata;
    assign cmd.ready = state == LT_DONE;

endmodule

// File: src/cache_ctrl.sv
// Cache controller: access buffer, hit/miss handling, RAM addressing and host ready.
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic host_re,
    input  mem_bus_pkg::strobe_t host_we,
    input  mem_bus_pkg::word_addr_t host_addr,
    input  mem_bus_pkg::word_t host_wdata,
    output mem_bus_pkg::word_t host_rdata,
    output logic host_ready,
    output logic tag_we,
    output cache_geom_pkg::set_idx_t tag_waddr,
    output cache_geom_pkg::tag_set_t tag_wdata,
    output cache_geom_pkg::set_idx_t tag_raddr,
    input  cache_geom_pkg::tag_set_t tag_rdata,
    output logic dat_we,
    output logic [`CACHE_WAYS-1:0] dat_wmask,
    output cache_geom_pkg::data_addr_t dat_waddr,
    output cache_geom_pkg::data_row_t dat_wdata,
    output cache_geom_pkg::data_addr_t dat_raddr,
    input  cache_geom_pkg::data_row_t dat_rdata,
    output cache_geom_pkg::tag_t req_tag,
    output cache_geom_pkg::way_t upd_way,
    output cache_geom_pkg::tag_entry_t upd_entry,
    output logic advance,
    input  logic hit,
    input  cache_geom_pkg::way_t hit_way,
    input  logic victim_dirty,
    input  cache_geom_pkg::tag_t victim_tag,
    input  cache_geom_pkg::tag_set_t new_set,
    input  cache_geom_pkg::data_addr_t lt_rd_addr,
    output mem_bus_pkg::word_t victim_data,
    input  logic fill_we,
    input  cache_geom_pkg::line_ofs_t fill_ofs,
    mem_port_if.ctrl seq_port
);

    typedef enum logic [2:0] {
        S_INIT,
        S_IDLE,
        S_READ,
        S_CHECK,
        S_MISS
    } state_t;

    state_t state;
    cache_geom_pkg::set_idx_t init_cnt;
    cache_geom_pkg::way_t miss_way;
    cache_geom_pkg::way_t wsel;

    // Access buffer.
    mem_bus_pkg::strobe_t ab_we;
    mem_bus_pkg::word_addr_t ab_addr;
    mem_bus_pkg::word_t ab_wdata;
    cache_geom_pkg::tag_t ab_tag;
    cache_geom_pkg::set_idx_t ab_set;
    cache_geom_pkg::line_ofs_t ab_ofs;

    mem_bus_pkg::word_addr_t victim_addr;
    mem_bus_pkg::word_t merged;
    logic lookup;
    logic write_hit;
    logic miss;

    assign {ab_tag, ab_set, ab_ofs} = ab_addr;

    // Tag RAM is swept clean after reset before any request is taken.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_INIT;
            init_cnt <= '0;
        end else begin
            case (state)
                S_INIT: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == `CACHE_SETS - 1) begin
                        state <= S_IDLE;
                    end
                end
                S_IDLE: if (host_re || |host_we) state <= S_READ;
                S_READ: state <= S_CHECK;
                S_CHECK: state <= hit ? S_IDLE : S_MISS;
                // Replay the buffered access once the line is in.
                S_MISS: if (seq_port.ready) state <= S_READ;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            ab_we <= host_we;
            ab_addr <= host_addr;
            ab_wdata <= host_wdata;
        end
        if (state == S_CHECK) begin
            miss_way <= tag_rdata.next;
        end
    end

    assign lookup = state == S_CHECK;
    assign write_hit = lookup && hit && |ab_we;
    assign miss = lookup && !hit;

    assign host_ready = lookup && hit;
    assign host_rdata = dat_rdata[hit_way];

    // Tag update: dirty on a write hit, clean allocation on a miss.
    assign req_tag = ab_tag;
    assign upd_way = hit ? hit_way : tag_rdata.next;
    assign upd_entry = '{valid: 1'b1, dirty: hit, tag: ab_tag};
    assign advance = !hit;

    assign tag_we = state == S_INIT || write_hit || miss;
    assign tag_waddr = (state == S_INIT) ? init_cnt : ab_set;
    assign tag_wdata = (state == S_INIT) ? '0 : new_set;
    assign tag_raddr = ab_set;

    always_comb begin
        merged = dat_rdata[hit_way];
        for (int b = 0; b < $bits(mem_bus_pkg::strobe_t); b++) begin
            if (ab_we[b]) begin
                merged[8*b +: 8] = ab_wdata[8*b +: 8];
            end
        end
    end

    // Sequencer owns the read port while a line moves.
    assign dat_raddr = (state == S_MISS) ? lt_rd_addr : {ab_set, ab_ofs};

    assign wsel = fill_we ? miss_way : hit_way;
    assign dat_we = write_hit || fill_we;
    assign dat_wmask = {{(`CACHE_WAYS-1){1'b0}}, 1'b1} << wsel;
    assign dat_waddr = fill_we ? {ab_set, fill_ofs} : {ab_set, ab_ofs};
    assign dat_wdata = fill_we ? {`CACHE_WAYS{seq_port.rdata}} : {`CACHE_WAYS{merged}};

    assign victim_data = dat_rdata[miss_way];

    // Miss command to the line sequencer.
    assign victim_addr = {victim_tag, ab_set, {`CACHE_OFS_W{1'b0}}};
    assign seq_port.re = miss && !victim_dirty;
    assign seq_port.we = (miss && victim_dirty) ? '1 : '0;
    assign seq_port.addr = ab_addr;
    assign seq_port.wdata = mem_bus_pkg::word_t'(victim_addr);

endmodule

// File: src/cache_top.sv
// Cache top level: controller, tag lookup, line sequencer, tag RAM and data RAM.
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_top (
    input  logic clk,
    input  logic rst_n,
    input  logic host_re,
    input  mem_bus_pkg::strobe_t host_we,
    input  mem_bus_pkg::word_addr_t host_addr,
    input  mem_bus_pkg::word_t host_wdata,
    output mem_bus_pkg::word_t host_rdata,
    output logic host_ready,
    output logic ext_re,
    output mem_bus_pkg::strobe_t ext_we,
    output mem_bus_pkg::word_addr_t ext_addr,
    output mem_bus_pkg::word_t ext_wdata,
    input  mem_bus_pkg::word_t ext_rdata,
    input  logic ext_ready
);

    logic tag_we;
    cache_geom_pkg::set_idx_t tag_waddr;
    cache_geom_pkg::set_idx_t tag_raddr;
    cache_geom_pkg::tag_set_t tag_wdata;
    cache_geom_pkg::tag_set_t tag_rdata;

    logic dat_we;
    logic [`CACHE_WAYS-1:0] dat_wmask;
    cache_geom_pkg::data_addr_t dat_waddr;
    cache_geom_pkg::data_addr_t dat_raddr;
    cache_geom_pkg::data_row_t dat_wdata;
    cache_geom_pkg::data_row_t dat_rdata;

    cache_geom_pkg::tag_t req_tag;
    cache_geom_pkg::way_t upd_way;
    cache_geom_pkg::tag_entry_t upd_entry;
    logic advance;
    logic hit;
    cache_geom_pkg::way_t hit_way;
    logic victim_dirty;
    cache_geom_pkg::tag_t victim_tag;
    cache_geom_pkg::tag_set_t new_set;

    cache_geom_pkg::data_addr_t lt_rd_addr;
    mem_bus_pkg::word_t victim_data;
    logic fill_we;
    cache_geom_pkg::line_ofs_t fill_ofs;

    // Miss command path.
    mem_port_if miss_port ();

    // Whole tag set is written at once.
    sdp_ram #(
        .payload_t(cache_geom_pkg::tag_set_t),
        .DEPTH(`CACHE_SETS),
        .LANES(1)
    ) u_tag_ram (
        .clk(clk), .we(tag_we), .wmask(1'b1), .waddr(tag_waddr),
        .wdata(tag_wdata), .raddr(tag_raddr), .rdata(tag_rdata)
    );

    sdp_ram #(
        .payload_t(cache_geom_pkg::data_row_t),
        .DEPTH(`CACHE_SETS * `CACHE_LINE_WORDS),
        .LANES(`CACHE_WAYS)
    ) u_data_ram (
        .clk(clk), .we(dat_we), .wmask(dat_wmask), .waddr(dat_waddr),
        .wdata(dat_wdata), .raddr(dat_raddr), .rdata(dat_rdata)
    );

    tag_lookup u_lookup (
        .tags(tag_rdata), .req_tag(req_tag), .upd_way(upd_way), .upd_entry(upd_entry),
        .advance(advance), .hit(hit), .hit_way(hit_way), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .new_set(new_set)
    );

    cache_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .host_re(host_re), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rdata(host_rdata), .host_ready(host_ready),
        .tag_we(tag_we), .tag_waddr(tag_waddr), .tag_wdata(tag_wdata),
        .tag_raddr(tag_raddr), .tag_rdata(tag_rdata),
        .dat_we(dat_we), .dat_wmask(dat_wmask), .dat_waddr(dat_waddr),
        .dat_wdata(dat_wdata), .dat_raddr(dat_raddr), .dat_rdata(dat_rdata),
        .req_tag(req_tag), .upd_way(upd_way), .upd_entry(upd_entry), .advance(advance),
        .hit(hit), .hit_way(hit_way), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .new_set(new_set),
        .lt_rd_addr(lt_rd_addr), .victim_data(victim_data),
        .fill_we(fill_we), .fill_ofs(fill_ofs),
        .seq_port(miss_port.ctrl)
    );

    line_transfer u_seq (
        .clk(clk), .rst_n(rst_n), .cmd(miss_port.seq),
        .rd_addr(lt_rd_addr), .victim_data(victim_data),
        .fill_we(fill_we), .fill_ofs(fill_ofs),
        .ext_re(ext_re), .ext_we(ext_we), .ext_addr(ext_addr),
        .ext_wdata(ext_wdata), .ext_rdata(ext_rdata), .ext_ready(ext_ready)
    );

endmodule

// File: testbench/cache_checker.sv
// Checker: reference word memory, tag model, host read and write-back data checks, protocol checks.
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_checker (
    input  logic clk,
    input  logic rst_n,
    input  logic host_re,
    input  mem_bus_pkg::strobe_t host_we,
    input  mem_bus_pkg::word_addr_t host_addr,
    input  mem_bus_pkg::word_t host_wdata,
    input  mem_bus_pkg::word_t host_rdata,
    input  logic host_ready,
    input  logic ext_re,
    input  mem_bus_pkg::strobe_t ext_we,
    input  mem_bus_pkg::word_addr_t ext_addr,
    input  mem_bus_pkg::word_t ext_wdata,
    input  logic ext_ready,
    output int errors,
    output int checks
);

    localparam int MEM_WORDS = 2 ** (`CACHE_ADDR_W - 2);
    localparam int LOW_W = `CACHE_OFS_W + `CACHE_SET_W;
    localparam mem_bus_pkg::strobe_t FULL_STROBE = '1;

    mem_bus_pkg::word_t ref_mem [MEM_WORDS];

    // Expected tag state, kept by the round-robin rule.
    logic model_valid [`CACHE_SETS][`CACHE_WAYS];
    logic model_dirty [`CACHE_SETS][`CACHE_WAYS];
    cache_geom_pkg::tag_t model_tag [`CACHE_SETS][`CACHE_WAYS];
    int model_next [`CACHE_SETS];
    logic expect_hit = 1'b0;
    logic expect_wb = 1'b0;
    mem_bus_pkg::word_addr_t wb_base = '0;

    logic pending = 1'b0;
    logic in_reset = 1'b0;
    int wait_cycles = 0;
    int wb_beats = 0;
    int fill_beats = 0;

    // Initial external memory contents, distinct for every word address.
    function automatic mem_bus_pkg::word_t pattern_word(input mem_bus_pkg::word_addr_t a);
        return (mem_bus_pkg::word_t'(a) * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
    endfunction

    task automatic compare_word(input string name, input mem_bus_pkg::word_t expected,
                                input mem_bus_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR at %0d ns: %s", $time, what);
    endtask

    task automatic expect_idle();
        compare_word("host_ready", '0, host_ready);
        compare_word("ext_re", '0, ext_re);
        compare_word("ext_we", '0, ext_we);
    endtask

    // Hit or miss from the tag model, allocation of the next way on a miss.
    task automatic predict_access();
        int set_i;
        int way;
        set_i = int'(host_addr[LOW_W-1:`CACHE_OFS_W]);
        way = -1;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (model_valid[set_i][w] &&
                model_tag[set_i][w] == host_addr[`CACHE_ADDR_W-3:LOW_W]) begin
                way = w;
            end
        end
        expect_hit = way >= 0;
        expect_wb = 1'b0;
        if (way < 0) begin
            way = model_next[set_i];
            expect_wb = model_valid[set_i][way] && model_dirty[set_i][way];
            wb_base = {model_tag[set_i][way], host_addr[LOW_W-1:`CACHE_OFS_W],
                       {`CACHE_OFS_W{1'b0}}};
            model_valid[set_i][way] = 1'b1;
            model_dirty[set_i][way] = 1'b0;
            model_tag[set_i][way] = host_addr[`CACHE_ADDR_W-3:LOW_W];
            model_next[set_i] = (way + 1) % `CACHE_WAYS;
        end
        if (|host_we) begin
            model_dirty[set_i][way] = 1'b1;
        end
    endtask

    // Victim words leave in offset order from the line the tag model evicts.
    task automatic check_wb_beat();
        mem_bus_pkg::word_addr_t addr;
        addr = {wb_base[`CACHE_ADDR_W-3:`CACHE_OFS_W],
                cache_geom_pkg::line_ofs_t'(wb_beats)};
        if (!pending || !expect_wb || fill_beats != 0) begin
            report_problem("external write outside a write-back phase");
        end
        compare_word("ext_we", FULL_STROBE, ext_we);
        compare_word("ext_addr", addr, ext_addr);
        compare_word("ext_wdata", ref_mem[addr], ext_wdata);
        wb_beats++;
    endtask

    task automatic check_fill_beat();
        if (!pending) begin
            report_problem("external read with no host request");
        end
        compare_word("ext_addr", {host_addr[`CACHE_ADDR_W-3:`CACHE_OFS_W],
                     cache_geom_pkg::line_ofs_t'(fill_beats)}, ext_addr);
        fill_beats++;
    endtask

    task automatic finish_access();
        checks++;
        if (!pending) begin
            report_problem("host_ready high with no request");
        end else begin
            if (expect_hit && (wb_beats != 0 || fill_beats != 0)) begin
                report_problem("hit moved data on the external port");
            end else if (expect_hit && wait_cycles != 2) begin
                report_problem($sformatf("hit took %0d cycles instead of 2", wait_cycles));
            end else if (!expect_hit && (fill_beats != `CACHE_LINE_WORDS ||
                         wb_beats != (expect_wb ? `CACHE_LINE_WORDS : 0))) begin
                report_problem($sformatf("miss moved %0d write and %0d read beats",
                               wb_beats, fill_beats));
            end
            if (|host_we) begin
                for (int b = 0; b < $bits(mem_bus_pkg::strobe_t); b++) begin
                    if (host_we[b]) begin
                        ref_mem[host_addr][8*b +: 8] = host_wdata[8*b +: 8];
                    end
                end
            end else begin
                compare_word("host_rdata", ref_mem[host_addr], host_rdata);
            end
        end
        pending = 1'b0;
        wb_beats = 0;
        fill_beats = 0;
    endtask

    initial begin
        errors = 0;
        checks = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = pattern_word(mem_bus_pkg::word_addr_t'(i));
        end
        for (int s = 0; s < `CACHE_SETS; s++) begin
            model_next[s] = 0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
                model_tag[s][w] = '0;
            end
        end
    end

    // Outputs settle after the rising edge, so sample in the middle of the cycle.
    always @(negedge clk) begin
        if (!rst_n) begin
            expect_idle();
            in_reset = 1'b1;
            pending = 1'b0;
            wb_beats = 0;
            fill_beats = 0;
        end else begin
            if (in_reset) begin
                expect_idle();
                in_reset = 1'b0;
            end
            if (|ext_we && ext_ready) begin
                check_wb_beat();
            end
            if (ext_re && ext_ready) begin
                check_fill_beat();
            end
            if (host_re || |host_we) begin
                if (pending) begin
                    wait_cycles++;
                end else begin
                    pending = 1'b1;
                    wait_cycles = 0;
                    predict_access();
                end
            end
            if (host_ready) begin
                finish_access();
            end
        end
    end

endmodule

// File: testbench/tb_cache.sv
// Testbench top: clock, reset, host stimulus, external memory model, timeout and summary.
`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_cache;

    localparam int MEM_WORDS = 2 ** (`CACHE_ADDR_W - 2);
    localparam int RANDOM_OPS = 2000;
    localparam int DIRECTED_OPS = 15;
    localparam int CYCLE_LIMIT = (RANDOM_OPS + DIRECTED_OPS) * (2 * `CACHE_LINE_WORDS * 4 + 10);

    logic clk;
    logic rst_n;
    logic host_re;
    mem_bus_pkg::strobe_t host_we;
    mem_bus_pkg::word_addr_t host_addr;
    mem_bus_pkg::word_t host_wdata;
    mem_bus_pkg::word_t host_rdata;
    logic host_ready;
    logic ext_re;
    mem_bus_pkg::strobe_t ext_we;
    mem_bus_pkg::word_addr_t ext_addr;
    mem_bus_pkg::word_t ext_wdata;
    mem_bus_pkg::word_t ext_rdata;
    logic ext_ready;

    mem_bus_pkg::word_t ext_mem [MEM_WORDS];
    int errors;
    int checks;
    int errors_before = 0;
    int cycles = 0;

    cache_top DUT (
        .clk(clk), .rst_n(rst_n),
        .host_re(host_re), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rdata(host_rdata), .host_ready(host_ready),
        .ext_re(ext_re), .ext_we(ext_we), .ext_addr(ext_addr),
        .ext_wdata(ext_wdata), .ext_rdata(ext_rdata), .ext_ready(ext_ready)
    );

    cache_checker u_check (
        .clk(clk), .rst_n(rst_n),
        .host_re(host_re), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rdata(host_rdata), .host_ready(host_ready),
        .ext_re(ext_re), .ext_we(ext_we), .ext_addr(ext_addr),
        .ext_wdata(ext_wdata), .ext_ready(ext_ready),
        .errors(errors), .checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a host request never completed", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // External memory with random ready; read data follows the registered address.
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            ext_mem[i] = u_check.pattern_word(mem_bus_pkg::word_addr_t'(i));
        end
        ext_ready = 1'b0;
        ext_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            ext_ready = ($urandom % 4) != 0;
            ext_rdata = ext_mem[ext_addr];
        end
    end

    // A write beat completes at the next rising edge.
    always @(negedge clk) begin
        if (rst_n && |ext_we && ext_ready) begin
            for (int b = 0; b < $bits(mem_bus_pkg::strobe_t); b++) begin
                if (ext_we[b]) begin
                    ext_mem[ext_addr][8*b +: 8] = ext_wdata[8*b +: 8];
                end
            end
        end
    end

    function automatic mem_bus_pkg::word_addr_t line_word(input int tag, input int set_i,
                                                           input int ofs);
        return {cache_geom_pkg::tag_t'(tag), cache_geom_pkg::set_idx_t'(set_i),
                cache_geom_pkg::line_ofs_t'(ofs)};
    endfunction

    // Holds the request until host_ready, then drops it 1 ns after the edge.
    task automatic host_access(input logic re, input mem_bus_pkg::strobe_t we,
                               input mem_bus_pkg::word_addr_t addr,
                               input mem_bus_pkg::word_t wdata);
        host_re = re;
        host_we = we;
        host_addr = addr;
        host_wdata = wdata;
        @(negedge clk);
        while (!host_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        host_re = 1'b0;
        host_we = '0;
    endtask

    task automatic read_word(input mem_bus_pkg::word_addr_t addr);
        host_access(1'b1, '0, addr, '0);
    endtask

    task automatic write_word(input mem_bus_pkg::word_addr_t addr,
                              input mem_bus_pkg::strobe_t strobe, input mem_bus_pkg::word_t data);
        host_access(1'b0, strobe, addr, data);
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d %s: %0d errors", num, name, errors - errors_before);
        errors_before = errors;
    endtask

    initial begin
        mem_bus_pkg::word_addr_t addr;

        void'($urandom(32'h637c));
        host_re = 1'b0;
        host_we = '0;
        host_addr = '0;
        host_wdata = '0;
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        report_test(1, "reset state");

        // Two cold lines, then hits at other offsets of the first one.
        read_word(line_word(8'h20, 1, 3));
        read_word(line_word(8'h20, 1, 0));
        read_word(line_word(8'h21, 2, 5));
        read_word(line_word(8'h20, 1, 7));
        report_test(2, "cold read misses");

        repeat (3) begin
            addr = line_word(8'h20, 1, $urandom % 8);
            write_word(addr, 1 + $urandom % 15, $urandom);
            read_word(addr);
        end
        report_test(3, "write hit merge");

        // Three tags in set 5 evict both dirty ways in turn.
        write_word(line_word(8'h40, 5, 2), 4'hf, $urandom);
        write_word(line_word(8'h41, 5, 6), 4'b0110, $urandom);
        read_word(line_word(8'h42, 5, 0));
        read_word(line_word(8'h40, 5, 2));
        read_word(line_word(8'h41, 5, 6));
        report_test(4, "round-robin eviction");

        for (int n = 0; n < RANDOM_OPS; n++) begin
            repeat ($urandom % 3) begin
                @(posedge clk);
                #1;
            end
            addr = line_word($urandom % 4, $urandom % 4, $urandom % 8);
            if ($urandom % 2) begin
                read_word(addr);
            end else begin
                write_word(addr, 1 + $urandom % 15, $urandom);
            end
        end
        report_test(5, "random traffic");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+include
src/cache_geom_pkg.sv
src/mem_bus_pkg.sv
src/mem_port_if.sv
src/sdp_ram.sv
src/tag_lookup.sv
src/line_transfer.sv
src/cache_ctrl.sv
src/cache_top.sv
testbench/cache_checker.sv
testbench/tb_cache.sv

// File: Bender.yml
package:
  name: cache_2way

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/cache_geom_pkg.sv
      - src/mem_bus_pkg.sv
      - src/mem_port_if.sv
      - src/sdp_ram.sv
      - src/tag_lookup.sv
      - src/line_transfer.sv
      - src/cache_ctrl.sv
      - src/cache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/cache_checker.sv
      - testbench/tb_cache.sv
